//--- src/delay_cfg.svh
`ifndef DELAY_CFG_SVH
`define DELAY_CFG_SVH

// Sample width in bits
`define DATA_W 16

// RAM holds 2**DEPTH_LOG2 entries
`define DEPTH_LOG2 4

// Fixed retiming around the RAM
`define IN_PIPE 2
`define OUT_PIPE 2

`endif

//--- src/delayPkg.sv
`include "delay_cfg.svh"

package delayPkg;

    typedef logic [`DATA_W-1:0] sample_t;

    // Legal taps are 1 to 15
    typedef logic [`DEPTH_LOG2-1:0] tap_t;
    typedef logic [`DEPTH_LOG2-1:0] addr_t;

    typedef logic [1:0] wbAddr_t;
    typedef logic [31:0] wbData_t;

    localparam wbAddr_t REG_CTRL = 2'd0;
    localparam wbAddr_t REG_DELAY = 2'd1;
    localparam wbAddr_t REG_STATUS = 2'd2;
    localparam wbAddr_t REG_COUNT = 2'd3;

    typedef enum logic [1:0] {
        IDLE,
        FLUSH,
        RUN
    } ctrlState_t;

endpackage

//--- src/hyperPipe.sv
module hyperPipe #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1,
    parameter bit RESETTABLE = 1'b0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    generate
        if (CYCLES == 0) begin : gWire
            assign dout = din;
        end else begin : gStages
            logic [WIDTH-1:0] stages [CYCLES];

            if (RESETTABLE) begin : gReset
                // Valid bits must come up low
                always_ff @(posedge clk) begin
                    if (rst) begin
                        for (int i = 0; i < CYCLES; i++) begin
                            stages[i] <= '0;
                        end
                    end else begin
                        stages[0] <= din;
                        for (int i = 1; i < CYCLES; i++) begin
                            stages[i] <= stages[i-1];
                        end
                    end
                end
            end else begin : gNoReset
                always_ff @(posedge clk) begin
                    stages[0] <= din;
                    for (int i = 1; i < CYCLES; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            assign dout = stages[CYCLES-1];
        end
    endgenerate

endmodule

//--- src/ramDelayLine.sv
`include "delay_cfg.svh"

module ramDelayLine (
    input  logic              clk,
    input  logic              rst,
    input  delayPkg::sample_t wrData,
    input  logic              wrValid,
    input  delayPkg::tap_t    tap,
    output delayPkg::sample_t rdData,
    output logic              rdValid
);
    import delayPkg::*;

    localparam int DEPTH = 1 << `DEPTH_LOG2;

    sample_t dataMem [DEPTH];
    logic    validMem [DEPTH];

    addr_t wrPtr;
    addr_t rdAddr;
    logic  primed;

    // Free-running write pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
        end else begin
            wrPtr <= addr_t'(wrPtr + 1'b1);
        end
    end

    // Set once every entry has been written since reset
    always_ff @(posedge clk) begin
        if (rst) begin
            primed <= 1'b0;
        end else if (wrPtr == '1) begin
            primed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        dataMem[wrPtr] <= wrData;
        validMem[wrPtr] <= wrValid;
    end

    // Entry written tap cycles ago
    assign rdAddr = addr_t'(wrPtr - tap);

    always_ff @(posedge clk) begin
        rdData <= dataMem[rdAddr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= primed & validMem[rdAddr];
        end
    end

endmodule

//--- src/delayCtrl.sv
module delayCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  delayPkg::wbAddr_t adr,
    input  delayPkg::wbData_t datIn,
    output delayPkg::wbData_t datOut,
    output logic              ack,
    input  logic              outValid,
    output delayPkg::tap_t    tap,
    output logic              accept
);
    import delayPkg::*;

    ctrlState_t state;
    addr_t      flushCnt;

    logic    enable;
    tap_t    tapReg;
    tap_t    tapWrite;
    wbData_t count;
    wbData_t rdMux;

    logic busReq;
    logic wrCtrl;
    logic wrDelay;
    logic startFlush;

    // New request, not yet acknowledged
    assign busReq = cyc & stb & ~ack;
    assign wrCtrl = busReq & we & (adr == REG_CTRL);
    assign wrDelay = busReq & we & (adr == REG_DELAY);

    // Zero tap is not allowed
    assign tapWrite = (datIn[$bits(tap_t)-1:0] == '0) ? tap_t'(1)
                                                    : tap_t'(datIn[$bits(tap_t)-1:0]);

    assign startFlush = (wrCtrl & datIn[0]) | (wrDelay & enable);

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= busReq;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            tapReg <= tap_t'(1);
        end else begin
            if (wrCtrl) begin
                enable <= datIn[0];
            end
            if (wrDelay) begin
                tapReg <= tapWrite;
            end
        end
    end

    // One pass over the whole RAM with accept low
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            flushCnt <= '0;
        end else if (wrCtrl && !datIn[0]) begin
            state <= IDLE;
        end else if (startFlush) begin
            state <= FLUSH;
            flushCnt <= '0;
        end else if (state == FLUSH) begin
            if (flushCnt == '1) begin
                state <= RUN;
            end
            flushCnt <= addr_t'(flushCnt + 1'b1);
        end
    end

    assign accept = (state == RUN);

    // Short tap while not running keeps old entries from being read twice
    assign tap = (state == RUN) ? tapReg : tap_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (outValid) begin
            count <= count + 1'b1;
        end
    end

    always_comb begin
        case (adr)
            REG_CTRL:   rdMux = wbData_t'(enable);
            REG_DELAY:  rdMux = wbData_t'(tapReg);
            REG_STATUS: rdMux = wbData_t'(state == RUN);
            default:    rdMux = count;
        endcase
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (busReq) begin
            datOut <= rdMux;
        end
    end

endmodule

//--- src/delayTop.sv
`include "delay_cfg.svh"

module delayTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  delayPkg::wbAddr_t adr,
    input  delayPkg::wbData_t datIn,
    output delayPkg::wbData_t datOut,
    output logic              ack,
    input  delayPkg::sample_t inData,
    input  logic              inValid,
    output delayPkg::sample_t outData,
    output logic              outValid
);
    import delayPkg::*;

    sample_t pipedData;
    logic    pipedValid;
    logic    wrValid;
    sample_t ramData;
    logic    ramValid;
    tap_t    tap;
    logic    accept;

    hyperPipe #(.CYCLES(`IN_PIPE), .WIDTH(`DATA_W), .RESETTABLE(1'b0)) inDataPipe (
        .clk  (clk),
        .rst  (rst),
        .din  (inData),
        .dout (pipedData)
    );

    hyperPipe #(.CYCLES(`IN_PIPE), .WIDTH(1), .RESETTABLE(1'b1)) inValidPipe (
        .clk  (clk),
        .rst  (rst),
        .din  (inValid),
        .dout (pipedValid)
    );

    // Samples outside RUN are stored as invalid
    assign wrValid = pipedValid & accept;

    ramDelayLine ram (
        .clk     (clk),
        .rst     (rst),
        .wrData  (pipedData),
        .wrValid (wrValid),
        .tap     (tap),
        .rdData  (ramData),
        .rdValid (ramValid)
    );

    hyperPipe #(.CYCLES(`OUT_PIPE), .WIDTH(`DATA_W), .RESETTABLE(1'b0)) outDataPipe (
        .clk  (clk),
        .rst  (rst),
        .din  (ramData),
        .dout (outData)
    );

    hyperPipe #(.CYCLES(`OUT_PIPE), .WIDTH(1), .RESETTABLE(1'b1)) outValidPipe (
        .clk  (clk),
        .rst  (rst),
        .din  (ramValid),
        .dout (outValid)
    );

    delayCtrl ctrl (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datIn    (datIn),
        .datOut   (datOut),
        .ack      (ack),
        .outValid (outValid),
        .tap      (tap),
        .accept   (accept)
    );

endmodule

//--- dv/delay_assert.sv
`include "delay_cfg.svh"

module delayAssert (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              ack,
    input  delayPkg::sample_t inData,
    input  delayPkg::sample_t outData,
    input  logic              outValid,
    input  delayPkg::tap_t    tap,
    input  logic              accept
);
    import delayPkg::*;

    // Input pipe, registered RAM read and output pipe
    localparam int FIXED_LAT = `IN_PIPE + 1 + `OUT_PIPE;

    int failCount = 0;

    // Tap seen by the RAM read that feeds the current output
    tap_t    tapHist [`OUT_PIPE + 1];
    sample_t expOut;

    always_ff @(posedge clk) begin
        tapHist[0] <= tap;
        for (int i = 1; i <= `OUT_PIPE; i++) begin
            tapHist[i] <= tapHist[i-1];
        end
    end

    // inData counts cycles, so its value tells the age of each sample
    assign expOut = sample_t'(inData - FIXED_LAT - tapHist[`OUT_PIPE]);

    ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
        cyc && stb && !ack |=> ack)
    else begin
        failCount++;
        $error("ack did not follow a new request");
    end

    ackOneCycle: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack)
    else begin
        failCount++;
        $error("ack stayed high for more than one cycle");
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(cyc && stb && !ack))
    else begin
        failCount++;
        $error("ack raised without a request in the previous cycle");
    end

    latencyOrder: assert property (@(posedge clk) disable iff (rst)
        outValid && accept |-> outData == expOut)
    else begin
        failCount++;
        $error("ERROR at %0t: outData is %h, expected %h",
               $time, $sampled(outData), $sampled(expOut));
    end

    validNeedsRun: assert property (@(posedge clk) disable iff (rst)
        outValid |-> $past(accept, `OUT_PIPE + 2))
    else begin
        failCount++;
        $error("outValid high without a preceding run");
    end

    // Nothing stale left over once a flush ends
    quietAfterFlush: assert property (@(posedge clk) disable iff (rst)
        $rose(accept) |-> !outValid [*`OUT_PIPE + 2])
    else begin
        failCount++;
        $error("outValid high right after the flush ended");
    end

endmodule

//--- dv/delayTb.sv
`include "delay_cfg.svh"

module delayTb;
    import delayPkg::*;

    localparam int BUS_TIMEOUT = 50;
    localparam int FLUSH_CYCLES = 1 << `DEPTH_LOG2;
    localparam int RUN_CYCLES = 60;
    localparam int IDLE_CYCLES = 25;
    localparam logic [31:0] LFSR_SEED = 32'hd26ab25d;

    logic    clk;
    logic    rst;
    logic    cyc;
    logic    stb;
    logic    we;
    wbAddr_t adr;
    wbData_t datIn;
    wbData_t datOut;
    logic    ack;
    sample_t inData;
    logic    inValid;
    sample_t outData;
    logic    outValid;

    logic [31:0] lfsr;
    logic        streamOn;
    int          seenValid;
    int          checkCount;
    int          errCount;

    delayTop delayTop_i (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datIn    (datIn),
        .datOut   (datOut),
        .ack      (ack),
        .inData   (inData),
        .inValid  (inValid),
        .outData  (outData),
        .outValid (outValid)
    );

    bind delayTop delayAssert protocolChecks (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .ack      (ack),
        .inData   (inData),
        .outData  (outData),
        .outValid (outValid),
        .tap      (tap),
        .accept   (accept)
    );

    always #2 clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // Free-running sample counter, valid from the LFSR
    always @(posedge clk) begin
        inData <= inData + 1'b1;
        if (streamOn) begin
            inValid <= lfsr[0];
            lfsr <= lfsrNext(lfsr);
        end else begin
            inValid <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst && outValid) begin
            seenValid <= seenValid + 1;
        end
    end

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    task automatic waitAck();
        int  n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < BUS_TIMEOUT) begin
            @(posedge clk);
            seen = ack;
            n++;
        end
        if (!seen) begin
            errCount++;
            $display("No ack from register %0d within %0d cycles", adr, n);
            endRun();
        end
    endtask

    task automatic writeReg(input wbAddr_t a, input wbData_t d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        adr <= a;
        datIn <= d;
        waitAck();
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic readReg(input wbAddr_t a, output wbData_t d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b0;
        adr <= a;
        waitAck();
        d = datOut;
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic checkValue(input string name, input wbData_t got, input wbData_t exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Set the tap, wait out the flush, then stream for a while
    task automatic runTap(input tap_t tapVal, input logic fromIdle);
        wbData_t rd;
        writeReg(REG_DELAY, wbData_t'(tapVal));
        if (fromIdle) begin
            writeReg(REG_CTRL, 32'd1);
        end
        readReg(REG_STATUS, rd);
        checkValue("STATUS", rd, 32'd0);
        readReg(REG_CTRL, rd);
        checkValue("CTRL", rd, 32'd1);
        readReg(REG_DELAY, rd);
        checkValue("DELAY", rd, wbData_t'(tapVal));
        waitCycles(FLUSH_CYCLES);
        readReg(REG_STATUS, rd);
        checkValue("STATUS", rd, 32'd1);
        waitCycles(RUN_CYCLES);
    endtask

    task automatic endRun();
        int assertFails;
        assertFails = delayTop_i.protocolChecks.failCount;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checkCount, errCount, assertFails);
        if (errCount == 0 && assertFails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        wbData_t rd;
        clk = 1'b0;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datIn = '0;
        inData = '0;
        inValid = 1'b0;
        streamOn = 1'b0;
        lfsr = LFSR_SEED;
        seenValid = 0;
        checkCount = 0;
        errCount = 0;

        waitCycles(2);
        rst <= 1'b0;
        streamOn <= 1'b1;

        // Register behavior while idle
        writeReg(REG_DELAY, 32'd0);
        readReg(REG_DELAY, rd);
        checkValue("DELAY", rd, 32'd1);
        writeReg(REG_DELAY, 32'h0000_0037);
        readReg(REG_DELAY, rd);
        checkValue("DELAY", rd, 32'd7);
        writeReg(REG_CTRL, 32'd0);
        readReg(REG_CTRL, rd);
        checkValue("CTRL", rd, 32'd0);
        readReg(REG_STATUS, rd);
        checkValue("STATUS", rd, 32'd0);

        runTap(tap_t'(1), 1'b1);
        // Retune during a run
        runTap(tap_t'(7), 1'b0);
        writeReg(REG_CTRL, 32'd0);
        readReg(REG_STATUS, rd);
        checkValue("STATUS", rd, 32'd0);
        runTap(tap_t'(15), 1'b1);

        // Drain the line before reading COUNT
        streamOn <= 1'b0;
        waitCycles(IDLE_CYCLES);
        readReg(REG_COUNT, rd);
        checkValue("COUNT", rd, wbData_t'(seenValid));
        if (seenValid == 0) begin
            errCount++;
            $display("No valid sample ever reached the output");
        end
        endRun();
    end

endmodule

//--- src.f
+incdir+src
src/delayPkg.sv
src/hyperPipe.sv
src/ramDelayLine.sv
src/delayCtrl.sv
src/delayTop.sv
dv/delay_assert.sv
dv/delayTb.sv

//--- Bender.yml
package:
  name: delay_line

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/delayPkg.sv
      - src/hyperPipe.sv
      - src/ramDelayLine.sv
      - src/delayCtrl.sv
      - src/delayTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/delay_assert.sv
      - dv/delayTb.sv
